/* design/core_pkg.sv */
// shared widths, window tag and audio constants
// packed structs for the reload command, destinations,
// SDRAM word requests and stereo samples

package core_pkg;

    //////////////////////////////////////////////////////////////////////
    // bridge and SDRAM word port
    //////////////////////////////////////////////////////////////////////

    localparam int BRIDGE_W = 32;
    // word address is bridge_addr[25:2]
    localparam int WORD_ADDR_W = 24;
    // bridge_addr[31:26] of the 64 MB SDRAM window
    localparam logic [5:0] SDRAM_WIN_TAG = 6'd0;
    // block RAM write strobe length in clk_74a cycles
    localparam logic [1:0] BRAM_HOLD_CYCLES = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // audio
    //////////////////////////////////////////////////////////////////////

    // 74.25 MHz in, 24.576 MHz toggle rate, 12.288 MHz MCLK
    localparam int MCLK_ACC_W = 15;
    localparam logic [MCLK_ACC_W-1:0] MCLK_ADD = 15'd4096;
    localparam logic [MCLK_ACC_W-1:0] MCLK_MAX = 15'd12375;
    // active bits per channel, then padding up to the slot
    localparam int SAMPLE_W = 16;
    localparam int I2S_SLOT_BITS = 32;

    // target data-slot read parameters
    typedef struct packed {
        logic [15:0] id;
        logic [31:0] slotoffset;
        logic [31:0] bridgeaddr;
        logic [31:0] length;
    } dataslot_cmd_t;

    // which memory the reload fills
    typedef struct packed {
        logic sdram;
        logic bram;
    } reload_sel_t;

    typedef struct packed {
        logic                   write;
        logic                   read;
        logic [WORD_ADDR_W-1:0] addr;
        logic [BRIDGE_W-1:0]    wdata;
        logic [3:0]             enable;
    } sdram_req_t;

    typedef struct packed {
        logic [SAMPLE_W-1:0] left;
        logic [SAMPLE_W-1:0] right;
    } audio_sample_t;

endpackage

/* design/dataslot_reload_fsm.sv */
// data-slot reload sequencer
// issues the target read command and tracks ack/done from the host

`timescale 1ns/1ps

module dataslot_reload_fsm (
    input  logic                    clk_74a,
    input  logic                    reset_n,
    input  logic                    set_sdram,
    input  logic                    set_bram,
    input  core_pkg::dataslot_cmd_t target_params,
    input  logic                    target_ack,
    input  logic                    target_done,
    output logic                    target_read,
    output logic                    ram_reloading,
    output core_pkg::dataslot_cmd_t target_cmd,
    output core_pkg::reload_sel_t   reload_sel
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_ACK,
        ST_WAIT_DONE
    } state_t;

    state_t state;

    //////////////////////////////////////////////////////////////////////
    // control state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!reset_n) begin
            state         <= ST_IDLE;
            target_read   <= 1'b0;
            ram_reloading <= 1'b0;
            reload_sel    <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // set pulses are only taken here
                    if (set_sdram || set_bram) begin
                        reload_sel.sdram <= set_sdram;
                        reload_sel.bram  <= set_bram;
                        ram_reloading    <= 1'b1;
                        target_read      <= 1'b1;
                        state            <= ST_WAIT_ACK;
                    end
                end
                ST_WAIT_ACK: begin
                    // read level holds until the host acks
                    if (target_ack) begin
                        target_read <= 1'b0;
                        state       <= ST_WAIT_DONE;
                    end
                end
                ST_WAIT_DONE: begin
                    // bridge writes land while we sit here
                    if (target_done) begin
                        reload_sel    <= '0;
                        ram_reloading <= 1'b0;
                        state         <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // command parameters, latched with the request
    always_ff @(posedge clk_74a) begin
        if (state == ST_IDLE && (set_sdram || set_bram)) begin
            target_cmd <= target_params;
        end
    end

endmodule

/* design/bridge_word_port.sv */
// bridge word write port for the SDRAM window
// block RAM strobe stretch and SDRAM request merge

`timescale 1ns/1ps

module bridge_word_port (
    input  logic                         clk_74a,
    input  logic                         reset_n,
    input  logic [core_pkg::BRIDGE_W-1:0] bridge_addr,
    input  logic [core_pkg::BRIDGE_W-1:0] bridge_wr_data,
    input  logic                         bridge_wr,
    input  core_pkg::reload_sel_t        reload_sel,
    input  core_pkg::sdram_req_t         core_req,
    output core_pkg::sdram_req_t         sdram_req,
    output logic                         core_stall,
    output logic                         bram_wr,
    output logic [core_pkg::BRIDGE_W-1:0] bram_wdata
);

    import core_pkg::*;

    logic                   win_hit;
    logic                   word_wr;
    logic [1:0]             bram_hold;
    logic [WORD_ADDR_W-1:0] word_addr;
    logic [BRIDGE_W-1:0]    word_data;

    // top six address bits select the window
    assign win_hit = bridge_wr && (bridge_addr[BRIDGE_W-1:WORD_ADDR_W+2] == SDRAM_WIN_TAG);

    //////////////////////////////////////////////////////////////////////
    // write capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!reset_n) begin
            word_wr   <= 1'b0;
            bram_hold <= 2'd0;
        end else begin
            // one-cycle SDRAM word write
            word_wr <= win_hit && reload_sel.sdram;
            // hold counter 1..BRAM_HOLD_CYCLES then back to idle
            if (win_hit && reload_sel.bram) begin
                bram_hold <= 2'd1;
            end else if (bram_hold == BRAM_HOLD_CYCLES) begin
                bram_hold <= 2'd0;
            end else if (bram_hold != 2'd0) begin
                bram_hold <= bram_hold + 2'd1;
            end
        end
    end

    // word address and data, shared by both destinations
    always_ff @(posedge clk_74a) begin
        if (win_hit && (reload_sel.sdram || reload_sel.bram)) begin
            word_addr <= bridge_addr[WORD_ADDR_W+1:2];
            word_data <= bridge_wr_data;
        end
    end

    assign bram_wr    = (bram_hold != 2'd0);
    assign bram_wdata = word_data;

    //////////////////////////////////////////////////////////////////////
    // request merge, bridge word wins
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (word_wr) begin
            sdram_req.write  = 1'b1;
            sdram_req.read   = 1'b0;
            sdram_req.addr   = word_addr;
            sdram_req.wdata  = word_data;
            sdram_req.enable = 4'b1111;
        end else begin
            sdram_req = core_req;
        end
    end

    // core holds its request while the bridge owns the port
    assign core_stall = word_wr;

endmodule

/* design/mclk_frac_gen.sv */
// fractional accumulator MCLK generator
// bit-clock divider giving a one-cycle bit enable

`timescale 1ns/1ps

module mclk_frac_gen (
    input  logic clk_74a,
    input  logic reset_n,
    output logic audio_mclk,
    output logic bit_en
);

    import core_pkg::*;

    logic [MCLK_ACC_W-1:0] count;
    logic [1:0]            bit_div;

    //////////////////////////////////////////////////////////////////////
    // 74.25 MHz * 4096 / 12375 = 24.576 MHz toggle rate
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!reset_n) begin
            count      <= '0;
            audio_mclk <= 1'b0;
            bit_div    <= 2'd0;
            bit_en     <= 1'b0;
        end else begin
            bit_en <= 1'b0;
            if (count >= MCLK_MAX) begin
                // wrap and toggle mclk
                count      <= count - MCLK_MAX + MCLK_ADD;
                audio_mclk <= ~audio_mclk;
                // rising toggle only
                if (!audio_mclk) begin
                    bit_div <= bit_div + 2'd1;
                    // every fourth mclk rise
                    bit_en  <= (bit_div == 2'd3);
                end
            end else begin
                count <= count + MCLK_ADD;
            end
        end
    end

endmodule

/* design/i2s_serializer.sv */
// I2S serializer
// 32-bit shift register, slot counter and LRCK
// 16 active bits per 32-bit channel slot

`timescale 1ns/1ps

module i2s_serializer (
    input  logic                    clk_74a,
    input  logic                    reset_n,
    input  logic                    bit_en,
    input  core_pkg::audio_sample_t sample,
    output logic                    audio_dac,
    output logic                    audio_lrck
);

    import core_pkg::*;

    localparam int CNT_W = $clog2(I2S_SLOT_BITS);

    logic [2*SAMPLE_W-1:0] shift;
    logic [CNT_W-1:0]      slot_cnt;

    //////////////////////////////////////////////////////////////////////
    // one step per bit event
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!reset_n) begin
            shift      <= '0;
            slot_cnt   <= '0;
            audio_dac  <= 1'b0;
            audio_lrck <= 1'b0;
        end else if (bit_en) begin
            // msb goes out first
            audio_dac <= shift[2*SAMPLE_W-1];
            slot_cnt  <= slot_cnt + 1'b1;
            if (slot_cnt == CNT_W'(I2S_SLOT_BITS - 1)) begin
                // end of slot, switch channel
                audio_lrck <= ~audio_lrck;
                // new frame starts with the left channel
                if (audio_lrck) begin
                    shift <= {sample.left, sample.right};
                end
            end else if (slot_cnt < CNT_W'(SAMPLE_W)) begin
                // active bits only, rest of slot is padding
                shift <= {shift[2*SAMPLE_W-2:0], 1'b0};
            end
        end
    end

endmodule

/* design/core_top.sv */
// top level
// reload sequencer, bridge word port, MCLK generator and I2S serializer

`timescale 1ns/1ps

module core_top (
    input  logic                          clk_74a,
    input  logic                          reset_n,
    // reload requests from the core
    input  logic                          set_sdram,
    input  logic                          set_bram,
    input  core_pkg::dataslot_cmd_t       target_params,
    // host target command handshake
    input  logic                          target_ack,
    input  logic                          target_done,
    output logic                          target_read,
    output logic                          ram_reloading,
    output core_pkg::dataslot_cmd_t       target_cmd,
    // bridge bus
    input  logic [core_pkg::BRIDGE_W-1:0] bridge_addr,
    input  logic                          bridge_wr,
    input  logic [core_pkg::BRIDGE_W-1:0] bridge_wr_data,
    // memory side
    input  core_pkg::sdram_req_t          core_req,
    output core_pkg::sdram_req_t          sdram_req,
    output logic                          core_stall,
    output logic                          bram_wr,
    output logic [core_pkg::BRIDGE_W-1:0] bram_wdata,
    // audio
    input  core_pkg::audio_sample_t       sample,
    output logic                          audio_mclk,
    output logic                          audio_dac,
    output logic                          audio_lrck
);

    import core_pkg::*;

    reload_sel_t reload_sel;
    logic        bit_en;

    dataslot_reload_fsm i_dataslot_reload_fsm (
        .clk_74a       (clk_74a),
        .reset_n       (reset_n),
        .set_sdram     (set_sdram),
        .set_bram      (set_bram),
        .target_params (target_params),
        .target_ack    (target_ack),
        .target_done   (target_done),
        .target_read   (target_read),
        .ram_reloading (ram_reloading),
        .target_cmd    (target_cmd),
        .reload_sel    (reload_sel)
    );

    bridge_word_port i_bridge_word_port (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_wr      (bridge_wr),
        .reload_sel     (reload_sel),
        .core_req       (core_req),
        .sdram_req      (sdram_req),
        .core_stall     (core_stall),
        .bram_wr        (bram_wr),
        .bram_wdata     (bram_wdata)
    );

    //////////////////////////////////////////////////////////////////////
    // audio, all on clk_74a enables
    //////////////////////////////////////////////////////////////////////

    mclk_frac_gen i_mclk_frac_gen (
        .clk_74a    (clk_74a),
        .reset_n    (reset_n),
        .audio_mclk (audio_mclk),
        .bit_en     (bit_en)
    );

    i2s_serializer i_i2s_serializer (
        .clk_74a    (clk_74a),
        .reset_n    (reset_n),
        .bit_en     (bit_en),
        .sample     (sample),
        .audio_dac  (audio_dac),
        .audio_lrck (audio_lrck)
    );

endmodule

/* testbench/tb_core_top.sv */
// testbench for core_top
// clock, reset, LCG stimulus and cycle timeout
// directed tests for reload, bridge word port, core passthrough and audio

`timescale 1ns/1ps

module tb_core_top;

    import core_pkg::*;

    localparam int TIMEOUT_CYCLES = 8000;
    localparam int AUDIO_CYCLES   = 4000;
    localparam int MCLK_WINDOW    = 2000;

    logic                clk_74a = 1'b0;
    logic                reset_n;
    logic                set_sdram;
    logic                set_bram;
    logic                target_ack;
    logic                target_done;
    logic                target_read;
    logic                ram_reloading;
    dataslot_cmd_t       target_params;
    dataslot_cmd_t       target_cmd;
    logic [BRIDGE_W-1:0] bridge_addr;
    logic [BRIDGE_W-1:0] bridge_wr_data;
    logic                bridge_wr;
    sdram_req_t          core_req;
    sdram_req_t          sdram_req;
    logic                core_stall;
    logic                bram_wr;
    logic [BRIDGE_W-1:0] bram_wdata;
    audio_sample_t       sample;
    logic                audio_mclk;
    logic                audio_dac;
    logic                audio_lrck;

    logic [31:0] lcg_state = 32'd29761;
    int          cycle_count = 0;

    // 10 MHz stand-in for the 74.25 MHz clock
    always #50 clk_74a = ~clk_74a;

    core_top i_core_top (.*);

    // hard stop if a handshake never arrives
    always @(posedge clk_74a) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Error at %0t ns: run did not finish within %0d cycles", $time, cycle_count);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // one edge then the drive point
    task automatic step();
        @(posedge clk_74a);
        #1;
    endtask

    task automatic fail_check(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic apply_reset();
        reset_n = 1'b0;
        repeat (5) step();
        reset_n = 1'b1;
    endtask

    // set pulse plus ack leaves the sequencer waiting for done
    task automatic start_reload(input logic to_sdram, input logic to_bram);
        set_sdram = to_sdram;
        set_bram  = to_bram;
        step();
        set_sdram  = 1'b0;
        set_bram   = 1'b0;
        target_ack = 1'b1;
        step();
        target_ack = 1'b0;
        assert (ram_reloading && !target_read) else fail_check("reload did not start");
    endtask

    task automatic finish_reload();
        assert (ram_reloading) else fail_check("ram_reloading dropped before target_done");
        target_done = 1'b1;
        step();
        target_done = 1'b0;
        assert (!ram_reloading) else fail_check("ram_reloading still high after done");
    endtask

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        step();
        bridge_wr = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        assert (!target_read && !ram_reloading && !core_stall && !bram_wr)
            else fail_check("control outputs not idle after reset");
        assert (!sdram_req.write && !audio_mclk && !audio_dac && !audio_lrck)
            else fail_check("memory or audio outputs not idle after reset");
    endtask

    task automatic sdram_reload_handshake();
        dataslot_cmd_t params;
        logic [31:0]   r0;
        logic [31:0]   r1;
        logic [31:0]   r2;
        logic [31:0]   r3;
        int            wait_cycles;
        r0 = lcg_next();
        r1 = lcg_next();
        r2 = lcg_next();
        r3 = lcg_next();
        params        = {r0[15:0], r1, r2, r3};
        target_params = params;
        set_sdram     = 1'b1;
        step();
        set_sdram = 1'b0;
        assert (target_read && ram_reloading) else fail_check("target_read not raised after set");
        assert (target_cmd == params)
            else fail_check($sformatf("target_cmd %h, expected %h", target_cmd, params));
        // host takes a while before the ack
        wait_cycles = 2 + int'(lcg_next() % 32'd5);
        repeat (wait_cycles) begin
            step();
            assert (target_read) else fail_check("target_read dropped before target_ack");
        end
        target_ack = 1'b1;
        step();
        target_ack = 1'b0;
        assert (!target_read) else fail_check("target_read still high after target_ack");
        // second request in wait-done with different parameters
        target_params = ~params;
        set_bram      = 1'b1;
        step();
        set_bram = 1'b0;
        step();
        assert (!target_read && target_cmd == params)
            else fail_check("set pulse taken while a reload was busy");
        finish_reload();
    endtask

    task automatic sdram_window_writes();
        logic [31:0] addr;
        logic [31:0] data;
        addr = lcg_next() & 32'h03ff_ffff;
        data = lcg_next();
        start_reload(1'b1, 1'b0);
        bridge_write(addr, data);
        assert (sdram_req.write && !sdram_req.read && core_stall)
            else fail_check("window write gave no SDRAM write with stall");
        assert (sdram_req.addr == addr[25:2] && sdram_req.wdata == data
                && sdram_req.enable == 4'hf)
            else fail_check($sformatf("sdram_req addr %h data %h, expected %h %h",
                                      sdram_req.addr, sdram_req.wdata, addr[25:2], data));
        step();
        assert (!sdram_req.write && !core_stall) else fail_check("SDRAM write longer than a cycle");
        // nonzero tag lands outside the window
        addr[31:26] = 6'd1 + 6'(lcg_next() % 32'd63);
        bridge_write(addr, data);
        assert (!sdram_req.write && !core_stall && !bram_wr)
            else fail_check("write outside the window was taken");
        finish_reload();
        addr[31:26] = 6'd0;
        bridge_write(addr, data);
        assert (!sdram_req.write && !core_stall) else fail_check("window write taken after done");
    endtask

    task automatic bram_write_strobe();
        logic [31:0] addr;
        logic [31:0] data;
        int          high_cycles;
        addr = lcg_next() & 32'h03ff_ffff;
        data = lcg_next();
        start_reload(1'b0, 1'b1);
        bridge_write(addr, data);
        high_cycles = 0;
        repeat (6) begin
            if (bram_wr) begin
                high_cycles++;
                assert (bram_wdata == data)
                    else fail_check($sformatf("bram_wdata %h, expected %h", bram_wdata, data));
            end
            assert (!sdram_req.write) else fail_check("SDRAM write during block RAM reload");
            step();
        end
        assert (high_cycles == 3)
            else fail_check($sformatf("bram_wr high %0d cycles, expected 3", high_cycles));
        finish_reload();
    endtask

    task automatic core_req_passthrough();
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        sdram_req_t  expected;
        repeat (8) begin
            r_hi     = lcg_next();
            r_lo     = lcg_next();
            expected = {r_hi[29:0], r_lo};
            core_req = expected;
            #10;
            assert (sdram_req == expected && !core_stall)
                else fail_check($sformatf("sdram_req %h, expected %h", sdram_req, expected));
            step();
        end
        core_req = '0;
    endtask

    task automatic audio_mclk_and_i2s();
        audio_sample_t smp;
        int            acc;
        int            cyc;
        int            model_toggles;
        int            dut_toggles;
        int            lrck_changes;
        int            slot_events;
        int            bit_idx;
        int            checked;
        logic          model_mclk;
        logic          prev_mclk;
        logic          prev_lrck;
        logic          event_pending;
        logic          exp_bit;
        logic [1:0]    div;
        smp    = lcg_next();
        sample = smp;
        // audio counts from reset so start it over
        apply_reset();
        acc           = 0;
        model_toggles = 0;
        dut_toggles   = 0;
        lrck_changes  = 0;
        slot_events   = 0;
        bit_idx       = SAMPLE_W;
        checked       = 0;
        model_mclk    = 1'b0;
        prev_mclk     = 1'b0;
        prev_lrck     = 1'b0;
        event_pending = 1'b0;
        div           = 2'd0;
        for (cyc = 0; cyc < AUDIO_CYCLES; cyc++) begin
            step();
            // serializer result of the bit event seen last cycle
            if (event_pending) begin
                slot_events++;
                if (audio_lrck != prev_lrck) begin
                    assert (slot_events == I2S_SLOT_BITS)
                        else fail_check($sformatf("lrck changed after %0d bit events, expected %0d",
                                                  slot_events, I2S_SLOT_BITS));
                    slot_events = 0;
                    lrck_changes++;
                    bit_idx = 0;
                end else if (lrck_changes >= 2 && bit_idx < SAMPLE_W) begin
                    exp_bit = audio_lrck ? smp.right[SAMPLE_W-1-bit_idx]
                                         : smp.left[SAMPLE_W-1-bit_idx];
                    assert (audio_dac == exp_bit)
                        else fail_check($sformatf("audio_dac bit %0d lrck %b is %b",
                                                  bit_idx, audio_lrck, audio_dac));
                    bit_idx++;
                    checked++;
                end
                prev_lrck = audio_lrck;
            end else begin
                assert (audio_lrck == prev_lrck)
                    else fail_check("audio_lrck changed without a bit event");
            end
            // accumulator model for the edge just taken
            event_pending = 1'b0;
            if (acc >= int'(MCLK_MAX)) begin
                acc        = acc - int'(MCLK_MAX) + int'(MCLK_ADD);
                model_mclk = ~model_mclk;
                if (cyc < MCLK_WINDOW) model_toggles++;
                // bit event on every fourth rise
                if (model_mclk) begin
                    event_pending = (div == 2'd3);
                    div           = div + 2'd1;
                end
            end else begin
                acc = acc + int'(MCLK_ADD);
            end
            if (cyc < MCLK_WINDOW && audio_mclk != prev_mclk) dut_toggles++;
            prev_mclk = audio_mclk;
        end
        assert (dut_toggles == model_toggles)
            else fail_check($sformatf("%0d mclk toggles, expected %0d", dut_toggles, model_toggles));
        assert (checked >= 3 * SAMPLE_W)
            else fail_check($sformatf("only %0d serial bits checked", checked));
    endtask

    //////////////////////////////////////////////////////////////////////
    // sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset_n        = 1'b0;
        set_sdram      = 1'b0;
        set_bram       = 1'b0;
        target_params  = '0;
        target_ack     = 1'b0;
        target_done    = 1'b0;
        bridge_addr    = '0;
        bridge_wr_data = '0;
        bridge_wr      = 1'b0;
        core_req       = '0;
        sample         = '0;
        apply_reset();
        check_reset_state();
        sdram_reload_handshake();
        sdram_window_writes();
        bram_write_strobe();
        core_req_passthrough();
        audio_mclk_and_i2s();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* flist.f */
design/core_pkg.sv
design/dataslot_reload_fsm.sv
design/bridge_word_port.sv
design/mclk_frac_gen.sv
design/i2s_serializer.sv
design/core_top.sv
testbench/tb_core_top.sv

/* Makefile */
TOP = tb_core_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
